/* Makefile */
# Verilator build and run for the memory tester testbench

TOOL      := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := tb_ramtest
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the run fails unless the log holds the pass line
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* adgen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// adgen: pseudo-random address and data sequence generator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module adgen #(
  parameter int ADDR_BITS = 10
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   next,
  output ramtest_pkg::mem_addr_t addr,
  output ramtest_pkg::mem_data_t data
);

  localparam logic [ADDR_BITS-1:0] A_TAPS =
    ramtest_pkg::ADDR_TAPS[ADDR_BITS][ADDR_BITS-1:0];
  localparam logic [ADDR_BITS-1:0] A_SEED =
    ramtest_pkg::ADDR_SEED[ADDR_BITS-1:0];

  logic [ADDR_BITS-1:0]    a;
  ramtest_pkg::lfsr_word_t d_hi;
  ramtest_pkg::lfsr_word_t d_lo;

  // one shift-right galois step of a data half
  function automatic ramtest_pkg::lfsr_word_t data_step(input ramtest_pkg::lfsr_word_t s);
    if (s[0]) begin
      return (s >> 1) ^ ramtest_pkg::DATA_TAPS;
    end
    return s >> 1;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      a    <= A_SEED;
      d_hi <= ramtest_pkg::DATA_SEED_HI;
      d_lo <= ramtest_pkg::DATA_SEED_LO;
    end else if (next) begin
      if (a[0]) begin
        a <= (a >> 1) ^ A_TAPS;
      end else begin
        a <= a >> 1;
      end
      d_hi <= data_step(d_hi);
      d_lo <= data_step(d_lo);
    end
  end

  assign addr = a;

  // 64 random bits followed by their complement
  assign data = {d_hi, d_lo, ~d_hi, ~d_lo};

endmodule

/* all.f */
ramtest_pkg.sv
adgen.sv
ramtest.sv
port_arbiter.sv
ramtest_top.sv
tb_mem_model.sv
tb_ramtest.sv

/* port_arbiter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// port_arbiter: merges instruction and data ports onto one memory
// bus, four-phase handshake on every side, alternating priority
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module port_arbiter #(
  parameter int ADDR_BITS = 10
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   inst_req,
  input  logic [ADDR_BITS-1:0]   inst_addr,
  output ramtest_pkg::mem_data_t inst_rdata,
  output logic                   inst_ack,
  input  logic                   data_req,
  input  logic                   data_we,
  input  logic [ADDR_BITS-1:0]   data_addr,
  input  ramtest_pkg::mem_data_t data_wdata,
  output ramtest_pkg::mem_data_t data_rdata,
  output logic                   data_ack,
  output logic                   mem_req,
  output logic                   mem_we,
  output logic [ADDR_BITS-1:0]   mem_addr,
  output ramtest_pkg::mem_data_t mem_wdata,
  input  ramtest_pkg::mem_data_t mem_rdata,
  input  logic                   mem_ack
);

  ramtest_pkg::arb_state_t state;
  logic                    sel_data;
  logic                    last_inst;
  logic                    start;
  logic                    pick_data;
  logic                    cur_req;

  assign start     = state == ramtest_pkg::ARB_IDLE && (inst_req || data_req);
  // data wins a tie only when instruction had the previous grant
  assign pick_data = data_req && (!inst_req || last_inst);
  assign cur_req   = sel_data ? data_req : inst_req;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ramtest_pkg::ARB_IDLE;
      sel_data  <= 1'b0;
      last_inst <= 1'b0;
      mem_req   <= 1'b0;
      mem_we    <= 1'b0;
      inst_ack  <= 1'b0;
      data_ack  <= 1'b0;
    end else begin
      case (state)
        ramtest_pkg::ARB_IDLE: begin
          if (start) begin
            sel_data  <= pick_data;
            last_inst <= !pick_data;
            mem_we    <= pick_data && data_we;
            mem_req   <= 1'b1;
            state     <= ramtest_pkg::ARB_GRANT;
          end
        end
        ramtest_pkg::ARB_GRANT: begin
          if (mem_ack) begin
            mem_req <= 1'b0;
            if (sel_data) begin
              data_ack <= 1'b1;
            end else begin
              inst_ack <= 1'b1;
            end
            state <= ramtest_pkg::ARB_RELEASE;
          end
        end
        ramtest_pkg::ARB_RELEASE: begin
          // port side and memory side both have to close before the next grant
          if (!cur_req) begin
            inst_ack <= 1'b0;
            data_ack <= 1'b0;
          end
          if (!cur_req && !mem_ack) begin
            state <= ramtest_pkg::ARB_IDLE;
          end
        end
        default: state <= ramtest_pkg::ARB_IDLE;
      endcase
    end
  end

  // request payload and captured read data
  always_ff @(posedge clk) begin
    if (start) begin
      mem_addr  <= pick_data ? data_addr : inst_addr;
      mem_wdata <= data_wdata;
    end
    if (state == ramtest_pkg::ARB_GRANT && mem_ack) begin
      if (sel_data) begin
        data_rdata <= mem_rdata;
      end else begin
        inst_rdata <= mem_rdata;
      end
    end
  end

endmodule

/* ramtest.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ramtest: paces instruction reads and data accesses on two timers
// and checks every word read back against the expected sequence
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module ramtest #(
  parameter int INST_PERIOD      = 37,
  parameter int INST_PHASE       = 19,
  parameter int DATA_PERIOD      = 17,
  parameter int DATA_PHASE       = 7,
  parameter int TEST_CYCLES_LOG2 = 10,
  parameter int ADDR_BITS        = 10
) (
  input  logic                   clk,
  input  logic                   rst,
  output logic                   inst_req,
  output ramtest_pkg::mem_addr_t inst_addr,
  input  ramtest_pkg::mem_data_t inst_rdata,
  input  logic                   inst_ack,
  output logic                   data_req,
  output logic                   data_we,
  output ramtest_pkg::mem_addr_t data_addr,
  output ramtest_pkg::mem_data_t data_wdata,
  input  ramtest_pkg::mem_data_t data_rdata,
  input  logic                   data_ack,
  output logic                   test_ended,
  output logic                   test_error
);

  localparam int INST_TW = $clog2(INST_PERIOD);
  localparam int DATA_TW = $clog2(DATA_PERIOD);

  ramtest_pkg::gen_state_t     inst_state;
  ramtest_pkg::gen_state_t     data_state;
  logic [INST_TW-1:0]          inst_timer;
  logic [DATA_TW-1:0]          data_timer;
  logic [TEST_CYCLES_LOG2-1:0] data_counter;
  logic                        inst_error;
  logic                        data_error;

  logic                   ir_next;
  logic                   dw_next;
  logic                   dr_next;
  ramtest_pkg::mem_addr_t ir_addr;
  ramtest_pkg::mem_addr_t dw_addr;
  ramtest_pkg::mem_addr_t dr_addr;
  ramtest_pkg::mem_data_t ir_data;
  ramtest_pkg::mem_data_t dw_data;
  ramtest_pkg::mem_data_t dr_data;

  // instruction port
  always_ff @(posedge clk) begin
    if (rst) begin
      inst_state <= ramtest_pkg::GEN_IDLE;
      inst_timer <= '0;
      inst_req   <= 1'b0;
      inst_error <= 1'b0;
    end else begin
      case (inst_state)
        ramtest_pkg::GEN_IDLE: begin
          if (!test_ended) begin
            if (inst_timer == INST_TW'(INST_PERIOD - 1)) begin
              inst_timer <= '0;
            end else begin
              inst_timer <= inst_timer + 1'b1;
            end
            if (inst_timer == INST_TW'(INST_PHASE)) begin
              inst_req   <= 1'b1;
              inst_state <= ramtest_pkg::GEN_REQUEST;
            end
          end
        end
        ramtest_pkg::GEN_REQUEST: begin
          if (inst_ack) begin
            inst_req   <= 1'b0;
            inst_state <= ramtest_pkg::GEN_RELEASE;
            if (inst_rdata != ir_data) begin
              inst_error <= 1'b1;
            end
          end
        end
        ramtest_pkg::GEN_RELEASE: begin
          if (!inst_ack) begin
            inst_state <= ramtest_pkg::GEN_IDLE;
          end
        end
        default: inst_state <= ramtest_pkg::GEN_IDLE;
      endcase
    end
  end

  // data port with every fourth cycle a read
  always_ff @(posedge clk) begin
    if (rst) begin
      data_state   <= ramtest_pkg::GEN_IDLE;
      data_timer   <= '0;
      data_req     <= 1'b0;
      data_we      <= 1'b0;
      data_counter <= '0;
      data_error   <= 1'b0;
    end else begin
      case (data_state)
        ramtest_pkg::GEN_IDLE: begin
          if (!test_ended) begin
            if (data_timer == DATA_TW'(DATA_PERIOD - 1)) begin
              data_timer <= '0;
            end else begin
              data_timer <= data_timer + 1'b1;
            end
            if (data_timer == DATA_TW'(DATA_PHASE)) begin
              data_req   <= 1'b1;
              data_we    <= ~&data_counter[1:0];
              data_state <= ramtest_pkg::GEN_REQUEST;
            end
          end
        end
        ramtest_pkg::GEN_REQUEST: begin
          if (data_ack) begin
            data_req     <= 1'b0;
            data_we      <= 1'b0;
            data_counter <= data_counter + 1'b1;
            data_state   <= ramtest_pkg::GEN_RELEASE;
            if (!data_we && data_rdata != dr_data) begin
              data_error <= 1'b1;
            end
          end
        end
        ramtest_pkg::GEN_RELEASE: begin
          if (!data_ack) begin
            data_state <= ramtest_pkg::GEN_IDLE;
          end
        end
        default: data_state <= ramtest_pkg::GEN_IDLE;
      endcase
    end
  end

  // generators step once per completed access since ack stays high for several cycles
  assign ir_next = inst_ack && inst_state == ramtest_pkg::GEN_REQUEST;
  assign dw_next = data_ack && data_state == ramtest_pkg::GEN_REQUEST && data_we;
  assign dr_next = data_ack && data_state == ramtest_pkg::GEN_REQUEST && !data_we;

  adgen #(.ADDR_BITS(ADDR_BITS)) gen_ir (
    .clk  (clk),
    .rst  (rst),
    .next (ir_next),
    .addr (ir_addr),
    .data (ir_data)
  );

  adgen #(.ADDR_BITS(ADDR_BITS)) gen_dw (
    .clk  (clk),
    .rst  (rst),
    .next (dw_next),
    .addr (dw_addr),
    .data (dw_data)
  );

  adgen #(.ADDR_BITS(ADDR_BITS)) gen_dr (
    .clk  (clk),
    .rst  (rst),
    .next (dr_next),
    .addr (dr_addr),
    .data (dr_data)
  );

  assign inst_addr  = ir_addr;
  assign data_addr  = data_we ? dw_addr : dr_addr;
  assign data_wdata = dw_data;

  assign test_ended = &data_counter;
  assign test_error = inst_error | data_error;

endmodule

/* ramtest_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ramtest package: RAM word and address types, LFSR feedback masks,
// seed values and the FSM state encodings of the memory tester
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package ramtest_pkg;

  // address width of the attached RAM
  localparam int MEM_ADDR_BITS = 10;

  typedef logic [127:0] mem_data_t;
  typedef logic [MEM_ADDR_BITS-1:0] mem_addr_t;
  typedef logic [31:0] lfsr_word_t;

  // shift-right galois feedback for both 32-bit data halves
  localparam lfsr_word_t DATA_TAPS = 32'hD000_0001;

  localparam lfsr_word_t DATA_SEED_HI = 32'h7F4D_514F;
  localparam lfsr_word_t DATA_SEED_LO = 32'h7537_7599;

  // maximal-length masks, one per address width 8..16
  localparam logic [16:8][15:0] ADDR_TAPS = {
    16'hD008,
    16'h6000,
    16'h3802,
    16'h1C80,
    16'h0E08,
    16'h0500,
    16'h0240,
    16'h0110,
    16'h00B8
  };

  // low byte nonzero so every width starts off the all-zero lockup
  localparam logic [15:0] ADDR_SEED = 16'h37DB;

  typedef enum logic [1:0] {ARB_IDLE, ARB_GRANT, ARB_RELEASE} arb_state_t;

  typedef enum logic [1:0] {GEN_IDLE, GEN_REQUEST, GEN_RELEASE} gen_state_t;

endpackage

/* ramtest_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ramtest_top: memory tester with its port arbiter, memory bus out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module ramtest_top #(
  parameter int INST_PERIOD      = 37,
  parameter int INST_PHASE       = 19,
  parameter int DATA_PERIOD      = 17,
  parameter int DATA_PHASE       = 7,
  parameter int TEST_CYCLES_LOG2 = 10,
  parameter int MEM_ADDR_BITS    = 10
) (
  input  logic                     clk,
  input  logic                     rst,
  output logic                     mem_req,
  output logic                     mem_we,
  output logic [MEM_ADDR_BITS-1:0] mem_addr,
  output ramtest_pkg::mem_data_t   mem_wdata,
  input  ramtest_pkg::mem_data_t   mem_rdata,
  input  logic                     mem_ack,
  output logic                     test_ended,
  output logic                     test_error
);

  logic                     inst_req;
  logic [MEM_ADDR_BITS-1:0] inst_addr;
  ramtest_pkg::mem_data_t   inst_rdata;
  logic                     inst_ack;
  logic                     data_req;
  logic                     data_we;
  logic [MEM_ADDR_BITS-1:0] data_addr;
  ramtest_pkg::mem_data_t   data_wdata;
  ramtest_pkg::mem_data_t   data_rdata;
  logic                     data_ack;

  ramtest #(
    .INST_PERIOD      (INST_PERIOD),
    .INST_PHASE       (INST_PHASE),
    .DATA_PERIOD      (DATA_PERIOD),
    .DATA_PHASE       (DATA_PHASE),
    .TEST_CYCLES_LOG2 (TEST_CYCLES_LOG2),
    .ADDR_BITS        (MEM_ADDR_BITS)
  ) u_ramtest (
    .clk        (clk),
    .rst        (rst),
    .inst_req   (inst_req),
    .inst_addr  (inst_addr),
    .inst_rdata (inst_rdata),
    .inst_ack   (inst_ack),
    .data_req   (data_req),
    .data_we    (data_we),
    .data_addr  (data_addr),
    .data_wdata (data_wdata),
    .data_rdata (data_rdata),
    .data_ack   (data_ack),
    .test_ended (test_ended),
    .test_error (test_error)
  );

  port_arbiter #(
    .ADDR_BITS (MEM_ADDR_BITS)
  ) u_port_arbiter (
    .clk        (clk),
    .rst        (rst),
    .inst_req   (inst_req),
    .inst_addr  (inst_addr),
    .inst_rdata (inst_rdata),
    .inst_ack   (inst_ack),
    .data_req   (data_req),
    .data_we    (data_we),
    .data_addr  (data_addr),
    .data_wdata (data_wdata),
    .data_rdata (data_rdata),
    .data_ack   (data_ack),
    .mem_req    (mem_req),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_rdata  (mem_rdata),
    .mem_ack    (mem_ack)
  );

endmodule

/* tb_mem_model.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tb_mem_model: behavioral 128-bit RAM on the four-phase memory bus,
// random latency, access tally and optional read-data corruption
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tb_mem_model #(
  parameter int ADDR_BITS = 10
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   mem_req,
  input  logic                   mem_we,
  input  logic [ADDR_BITS-1:0]   mem_addr,
  input  ramtest_pkg::mem_data_t mem_wdata,
  output ramtest_pkg::mem_data_t mem_rdata,
  output logic                   mem_ack,
  input  logic                   corrupt_en,
  output int                     write_count,
  output int                     read_count
);

  ramtest_pkg::mem_data_t ram [0:(1<<ADDR_BITS)-1];
  int                     wait_left;
  logic                   busy;
  logic                   corrupted;

  // fill so that an unwritten word never looks like test data
  initial begin
    for (int i = 0; i < (1 << ADDR_BITS); i++) begin
      ram[i] = {4{32'hC3A5_0000 ^ 32'(i)}};
    end
    mem_rdata = '0;
    mem_ack   = 1'b0;
  end

  always @(posedge clk) begin : respond
    ramtest_pkg::mem_data_t rd;
    if (rst) begin
      mem_ack     <= 1'b0;
      busy        <= 1'b0;
      wait_left   <= 0;
      corrupted   <= 1'b0;
      write_count <= 0;
      read_count  <= 0;
    end else if (mem_ack) begin
      // hold ack until the requester lets go
      if (!mem_req) begin
        mem_ack <= 1'b0;
      end
    end else if (busy) begin
      if (wait_left > 1) begin
        wait_left <= wait_left - 1;
      end else begin
        busy    <= 1'b0;
        mem_ack <= 1'b1;
        if (mem_we) begin
          ram[mem_addr] <= mem_wdata;
          write_count   <= write_count + 1;
        end else begin
          rd = ram[mem_addr];
          // only the first read after corrupt_en rises is damaged
          if (corrupt_en && !corrupted) begin
            rd[0]     = ~rd[0];
            corrupted <= 1'b1;
          end
          mem_rdata  <= rd;
          read_count <= read_count + 1;
        end
      end
    end else if (mem_req) begin
      busy      <= 1'b1;
      wait_left <= 1 + int'($urandom % 6);
    end
  end

endmodule

/* tb_ramtest.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tb_ramtest: runs the memory tester against a RAM model, checks the
// bus handshake, the access tally and detection of a corrupted read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tb_ramtest;

  localparam int ADDR_BITS        = ramtest_pkg::MEM_ADDR_BITS;
  localparam int TEST_CYCLES_LOG2 = 10;
  // counter values 0 up to all ones minus one with each fourth one a read
  localparam int DATA_CYCLES      = (1 << TEST_CYCLES_LOG2) - 1;
  localparam int DATA_READS       = DATA_CYCLES / 4;
  localparam int DATA_WRITES      = DATA_CYCLES - DATA_READS;
  localparam int RUN_LIMIT        = 100000;
  localparam int QUIET_SPAN       = 16;
  localparam int IDLE_SPAN        = 200;

  logic                   clk;
  logic                   rst;
  logic                   corrupt_en;
  logic                   mem_req;
  logic                   mem_we;
  logic [ADDR_BITS-1:0]   mem_addr;
  ramtest_pkg::mem_data_t mem_wdata;
  ramtest_pkg::mem_data_t mem_rdata;
  logic                   mem_ack;
  logic                   test_ended;
  logic                   test_error;
  int                     write_count;
  int                     read_count;

  int                     errors;
  int                     timeouts;
  logic                   clean_run;
  logic [1:0]             rst_hist;
  logic                   prev_req;
  logic                   prev_ack;
  logic                   prev_we;
  logic [ADDR_BITS-1:0]   prev_addr;
  ramtest_pkg::mem_data_t prev_wdata;
  logic                   prev_ended;
  logic                   prev_error;
  logic                   written [0:(1<<ADDR_BITS)-1];

  ramtest_top #(
    .TEST_CYCLES_LOG2 (TEST_CYCLES_LOG2),
    .MEM_ADDR_BITS    (ADDR_BITS)
  ) dut (
    .clk        (clk),
    .rst        (rst),
    .mem_req    (mem_req),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_rdata  (mem_rdata),
    .mem_ack    (mem_ack),
    .test_ended (test_ended),
    .test_error (test_error)
  );

  tb_mem_model #(.ADDR_BITS(ADDR_BITS)) ram_model (
    .clk         (clk),
    .rst         (rst),
    .mem_req     (mem_req),
    .mem_we      (mem_we),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_rdata   (mem_rdata),
    .mem_ack     (mem_ack),
    .corrupt_en  (corrupt_en),
    .write_count (write_count),
    .read_count  (read_count)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_count(input string name, input int expected, input int actual);
    assert (actual == expected) else begin
      errors++;
      $display("[FAIL] %s expected %0d actual %0d", name, expected, actual);
    end
  endtask

  task automatic check_word(input string name, input logic [127:0] expected,
                            input logic [127:0] actual);
    assert (actual == expected) else begin
      errors++;
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic report(input string what);
    errors++;
    $display("error at %0t: %s", $time, what);
  endtask

  task automatic timed_out(input string what);
    timeouts++;
    $display("timeout at %0t: %s", $time, what);
  endtask

  // bus protocol checks plus reset values and sticky status on every edge
  always @(posedge clk) begin
    if (rst_hist[0] || rst_hist[1]) begin
      check_count("reset mem_req", 0, int'(mem_req));
      check_count("reset test_ended", 0, int'(test_ended));
      check_count("reset test_error", 0, int'(test_error));
    end
    if (!rst && !rst_hist[0]) begin
      assert (!prev_req || mem_req || prev_ack) else
        report("mem_req fell before mem_ack rose");
      if (prev_req && mem_req) begin
        check_word("mem_addr stable", 128'(prev_addr), 128'(mem_addr));
        check_word("mem_we stable", 128'(prev_we), 128'(mem_we));
        check_word("mem_wdata stable", prev_wdata, mem_wdata);
      end
      assert (prev_ack || !mem_ack || mem_req) else
        report("mem_ack rose while mem_req was low");
      assert (prev_req || !mem_req || !prev_ack) else
        report("mem_req rose again while mem_ack was high");
      // a read may only hit a word written earlier in this run
      if (mem_req && mem_ack && !prev_ack && !mem_we) begin
        assert (written[mem_addr]) else
          report($sformatf("read of address %0h before any write", mem_addr));
      end
      assert (test_ended || !prev_ended) else
        report("test_ended fell without a reset");
      assert (test_error || !prev_error) else
        report("test_error fell without a reset");
      if (clean_run) begin
        assert (!test_error || prev_error) else
          report("test_error rose in the clean run");
      end
    end
    if (rst) begin
      for (int i = 0; i < (1 << ADDR_BITS); i++) begin
        written[i] <= 1'b0;
      end
    end else if (mem_req && mem_ack && !prev_ack && mem_we) begin
      written[mem_addr] <= 1'b1;
    end
    rst_hist   <= {rst_hist[0], rst};
    prev_req   <= mem_req;
    prev_ack   <= mem_ack;
    prev_we    <= mem_we;
    prev_addr  <= mem_addr;
    prev_wdata <= mem_wdata;
    prev_ended <= test_ended;
    prev_error <= test_error;
  end

  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
  endtask

  task automatic wait_for_ended(output logic ok);
    int n;
    n = 0;
    while (!test_ended && n < RUN_LIMIT) begin
      @(posedge clk);
      n++;
    end
    ok = test_ended;
    if (!ok) begin
      timed_out("test_ended never rose");
    end
  endtask

  // wait until test_error or test_ended rises
  task automatic wait_for_error(output logic ok);
    int n;
    n = 0;
    while (!test_error && !test_ended && n < RUN_LIMIT) begin
      @(posedge clk);
      n++;
    end
    ok = test_error || test_ended;
    if (!ok) begin
      timed_out("neither test_error nor test_ended rose");
    end
  endtask

  task automatic wait_for_reads(input int count, output logic ok);
    int n;
    n = 0;
    while (read_count < count && n < RUN_LIMIT) begin
      @(posedge clk);
      n++;
    end
    ok = read_count >= count;
    if (!ok) begin
      timed_out("the RAM model never served enough reads");
    end
  endtask

  task automatic wait_for_quiet(output logic ok);
    int n;
    int calm;
    n = 0;
    calm = 0;
    while (calm < QUIET_SPAN && n < RUN_LIMIT) begin
      @(posedge clk);
      n++;
      if (mem_req || mem_ack) begin
        calm = 0;
      end else begin
        calm++;
      end
    end
    ok = calm >= QUIET_SPAN;
    if (!ok) begin
      timed_out("the memory bus never went quiet");
    end
  endtask

  task automatic run_tests();
    logic ok;
    int   pick;
    // clean run
    clean_run <= 1'b1;
    apply_reset();
    wait_for_ended(ok);
    if (!ok) return;
    check_count("writes at end", DATA_WRITES, write_count);
    assert (read_count >= DATA_READS) else begin
      errors++;
      $display("[FAIL] reads at end expected at least %0d actual %0d",
               DATA_READS, read_count);
    end
    wait_for_quiet(ok);
    if (!ok) return;
    for (int i = 0; i < IDLE_SPAN; i++) begin
      @(posedge clk);
      assert (!mem_req) else report("mem_req rose after the test ended");
    end
    // fault run with bit 0 of one read flipped
    clean_run <= 1'b0;
    apply_reset();
    pick = 1 + int'($urandom % 32);
    wait_for_reads(pick, ok);
    if (!ok) return;
    corrupt_en <= 1'b1;
    wait_for_error(ok);
    if (!ok) return;
    check_count("test_error before end", 1, int'(test_error));
    check_count("test_ended at error", 0, int'(test_ended));
    wait_for_ended(ok);
    if (!ok) return;
    check_count("test_error at end", 1, int'(test_error));
    corrupt_en <= 1'b0;
    apply_reset();
    repeat (2) @(posedge clk);
  endtask

  initial begin
    void'($urandom(92));
    rst        = 1'b1;
    corrupt_en = 1'b0;
    clean_run  = 1'b0;
    rst_hist   = 2'b00;
    errors     = 0;
    timeouts   = 0;
    run_tests();
    $display("checks failed: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
